// File: Makefile
TOP = tb_angle_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) \
		-f list.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^Test OK$$" sim.log || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: list.f
rtl/angle_pkg.sv
rtl/tilt_angle_target.sv
rtl/yaw_angle_accumulator.sv
rtl/angle_stage_sequencer.sv
rtl/angle_stage_top.sv
tb/tb_angle_stage.sv

// File: rtl/angle_pkg.sv
// angle stage types and constants; angles are s12.4 two's complement with 360 deg = 5760
package angle_pkg;

	typedef logic signed [15:0] angle_t;      // degrees, 4 fractional bits
	typedef logic signed [16:0] angle_wide_t; // angle difference with one guard bit
	typedef logic [7:0] stick_t;              // receiver value 0..250, 125 at center
	typedef logic signed [8:0] stick_ofs_t;   // stick minus center
	typedef logic signed [17:0] yaw_track_t;  // heading at 4x angle resolution

	typedef struct packed {
		stick_t throttle;
		stick_t roll;
		stick_t pitch;
		stick_t yaw;
	} rx_sticks_t;

	typedef struct packed {
		angle_t roll;
		angle_t pitch;
		angle_t yaw;
	} imu_angles_t;

	typedef struct packed {
		angle_t roll_error;
		angle_t pitch_error;
		angle_t yaw_error;
		angle_t yaw_target;
	} angle_result_t;

	typedef enum logic [2:0] {
		YAW_WAIT,
		YAW_TRACK,
		YAW_TARGET,
		YAW_ERROR,
		YAW_LIMIT,
		YAW_DONE
	} yaw_state_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_FINISH
	} seq_state_t;

	localparam angle_t ANGLE_360 = 16'sd5760;
	localparam angle_t ANGLE_270 = 16'sd4320;
	localparam angle_t ANGLE_90 = 16'sd1440;
	localparam angle_t ERROR_LIMIT = ANGLE_90;
	localparam yaw_track_t TRACK_360 = yaw_track_t'(ANGLE_360) * 4; // 23040

	localparam stick_t STICK_CENTER = 8'd125;
	localparam stick_t THROTTLE_OFF = 8'd10;  // below this the motors are off
	localparam stick_t NEUTRAL_LO = 8'd120;   // neutral window is exclusive
	localparam stick_t NEUTRAL_HI = 8'd130;
	localparam int TILT_SHIFT = 3;            // full stick gives +/-62.5 deg

	// signed distance of a stick from center, -125..125
	function automatic stick_ofs_t stick_offset(input stick_t s);
		return $signed({1'b0, s}) - $signed({1'b0, STICK_CENTER});
	endfunction

	// saturate an error to +/-ERROR_LIMIT
	function automatic angle_t clamp_error(input angle_wide_t e);
		if (e > angle_wide_t'(ERROR_LIMIT))
			return ERROR_LIMIT;
		if (e < -angle_wide_t'(ERROR_LIMIT))
			return -ERROR_LIMIT;
		return angle_t'(e);
	endfunction

endpackage

// File: rtl/angle_stage_sequencer.sv
// run control; a start while busy is dropped, unit outputs must hold from their done to the result
`timescale 1ns/1ps

module angle_stage_sequencer (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  logic                     start,
	input  angle_pkg::rx_sticks_t    sticks,
	input  angle_pkg::imu_angles_t   imu,
	output angle_pkg::rx_sticks_t    snap_sticks,
	output angle_pkg::imu_angles_t   snap_imu,
	output logic                     go,
	input  logic                     yaw_done,
	input  logic                     roll_done,
	input  logic                     pitch_done,
	input  angle_pkg::angle_t        yaw_target,
	input  angle_pkg::angle_t        yaw_error,
	input  angle_pkg::angle_t        roll_error,
	input  angle_pkg::angle_t        pitch_error,
	output logic                     busy,
	output logic                     done,
	output angle_pkg::angle_result_t result
);

	angle_pkg::seq_state_t state;
	logic [2:0] seen;       // sticky completions, yaw roll pitch
	logic [2:0] seen_next;
	logic launch;
	logic all_done;

	assign busy = (state == angle_pkg::SEQ_RUN);
	assign done = (state == angle_pkg::SEQ_FINISH);  // one cycle, result valid alongside
	assign launch = start && !busy;
	assign seen_next = seen | {yaw_done, roll_done, pitch_done};
	assign all_done = busy && (&seen_next);  // units may finish in any order

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= angle_pkg::SEQ_IDLE;
			seen <= '0;
			go <= 1'b0;
		end else begin
			go <= launch;  // units see go together with the fresh snapshot
			case (state)
				angle_pkg::SEQ_IDLE, angle_pkg::SEQ_FINISH: begin
					if (launch) begin
						state <= angle_pkg::SEQ_RUN;
						seen <= '0;
					end else begin
						state <= angle_pkg::SEQ_IDLE;
					end
				end
				angle_pkg::SEQ_RUN: begin
					seen <= seen_next;
					if (all_done)
						state <= angle_pkg::SEQ_FINISH;
				end
				default: state <= angle_pkg::SEQ_IDLE;
			endcase
		end
	end

	// snapshot stays put from one launch to the next
	always_ff @(posedge us_clk) begin
		if (launch) begin
			snap_sticks <= sticks;
			snap_imu <= imu;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			result <= '0;
		end else if (all_done) begin
			result <= '{
				roll_error:  roll_error,
				pitch_error: pitch_error,
				yaw_error:   yaw_error,
				yaw_target:  yaw_target
			};
		end
	end

endmodule

// File: rtl/angle_stage_top.sv
// angle stage top; fixed 7-cycle latency from start to done, no back-pressure
`timescale 1ns/1ps

module angle_stage_top (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  logic                     start,
	input  angle_pkg::rx_sticks_t    sticks,
	input  angle_pkg::imu_angles_t   imu,
	output logic                     busy,
	output logic                     done,
	output angle_pkg::angle_result_t result
);

	angle_pkg::rx_sticks_t  snap_sticks;
	angle_pkg::imu_angles_t snap_imu;
	logic                   go;
	logic                   yaw_done;
	logic                   roll_done;
	logic                   pitch_done;
	angle_pkg::angle_t      yaw_target;
	angle_pkg::angle_t      yaw_error;
	angle_pkg::angle_t      roll_error;
	angle_pkg::angle_t      pitch_error;

	angle_stage_sequencer i_seq (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.sticks      (sticks),
		.imu         (imu),
		.snap_sticks (snap_sticks),
		.snap_imu    (snap_imu),
		.go          (go),
		.yaw_done    (yaw_done),
		.roll_done   (roll_done),
		.pitch_done  (pitch_done),
		.yaw_target  (yaw_target),
		.yaw_error   (yaw_error),
		.roll_error  (roll_error),
		.pitch_error (pitch_error),
		.busy        (busy),
		.done        (done),
		.result      (result)
	);

	yaw_angle_accumulator i_yaw (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.go         (go),
		.throttle   (snap_sticks.throttle),
		.yaw_stick  (snap_sticks.yaw),
		.imu_yaw    (snap_imu.yaw),
		.done       (yaw_done),
		.yaw_target (yaw_target),
		.yaw_error  (yaw_error)
	);

	tilt_angle_target i_roll (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.go          (go),
		.throttle    (snap_sticks.throttle),
		.stick       (snap_sticks.roll),
		.imu_angle   (snap_imu.roll),
		.done        (roll_done),
		.angle_error (roll_error)
	);

	tilt_angle_target i_pitch (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.go          (go),
		.throttle    (snap_sticks.throttle),
		.stick       (snap_sticks.pitch),
		.imu_angle   (snap_imu.pitch),
		.done        (pitch_done),
		.angle_error (pitch_error)
	);

endmodule

// File: rtl/tilt_angle_target.sv
// tilt axis unit; stick and imu_angle must hold from go to done, error is clamped to +/-90 deg
`timescale 1ns/1ps

module tilt_angle_target (
	input  logic              us_clk,
	input  logic              resetn,
	input  logic              go,
	input  angle_pkg::stick_t throttle,
	input  angle_pkg::stick_t stick,
	input  angle_pkg::angle_t imu_angle,
	output logic              done,
	output angle_pkg::angle_t angle_error
);

	logic [1:0] stage_v;             // stage enables trailing the sampled go
	logic throttle_off;
	angle_pkg::angle_t target;
	angle_pkg::angle_wide_t diff;    // target minus imu, one guard bit

	assign throttle_off = throttle < angle_pkg::THROTTLE_OFF;
	assign diff = angle_pkg::angle_wide_t'(target) - angle_pkg::angle_wide_t'(imu_angle);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			stage_v <= '0;
			done <= 1'b0;
		end else begin
			stage_v <= {stage_v[0], go};
			done <= stage_v[1];  // fixed 2 cycles after go is sampled
		end
	end

	// stage one, stick to target
	always_ff @(posedge us_clk) begin
		if (stage_v[0]) begin
			if (throttle_off)
				target <= '0;
			else
				target <= angle_pkg::angle_t'(angle_pkg::stick_offset(stick)) <<<
					angle_pkg::TILT_SHIFT;
		end
	end

	// stage two, error held until the next run
	always_ff @(posedge us_clk) begin
		if (stage_v[1])
			angle_error <= angle_pkg::clamp_error(diff);
	end

endmodule

// File: rtl/yaw_angle_accumulator.sv
// yaw unit; inputs must hold from go to done, imu_yaw is expected in 0..360 deg, heading persists
`timescale 1ns/1ps

module yaw_angle_accumulator (
	input  logic              us_clk,
	input  logic              resetn,
	input  logic              go,
	input  angle_pkg::stick_t throttle,
	input  angle_pkg::stick_t yaw_stick,
	input  angle_pkg::angle_t imu_yaw,
	output logic              done,
	output angle_pkg::angle_t yaw_target,
	output angle_pkg::angle_t yaw_error
);

	angle_pkg::yaw_state_t state;
	angle_pkg::yaw_track_t track;       // heading target, 0..TRACK_360
	angle_pkg::yaw_track_t track_step;  // track plus stick offset, wrapped
	angle_pkg::yaw_track_t imu_track;   // imu_yaw at accumulator scale
	angle_pkg::angle_wide_t diff_next;
	angle_pkg::angle_wide_t yaw_diff;   // unclamped error
	logic out_of_neutral;               // stick left the neutral window since last resync
	logic throttle_off;
	logic stick_neutral;

	assign throttle_off = throttle < angle_pkg::THROTTLE_OFF;
	assign stick_neutral = (yaw_stick > angle_pkg::NEUTRAL_LO) &&
		(yaw_stick < angle_pkg::NEUTRAL_HI);
	assign imu_track = angle_pkg::yaw_track_t'(imu_yaw) <<< 2;

	// one integration step, folded back into one turn
	always_comb begin
		angle_pkg::yaw_track_t sum;
		sum = track + angle_pkg::yaw_track_t'(angle_pkg::stick_offset(yaw_stick));
		if (sum > angle_pkg::TRACK_360)
			track_step = sum - angle_pkg::TRACK_360;
		else if (sum < 0)
			track_step = sum + angle_pkg::TRACK_360;
		else
			track_step = sum;
	end

	// shortest way across the 0/360 seam when target and imu sit on opposite sides
	always_comb begin
		angle_pkg::angle_wide_t tgt_w;
		angle_pkg::angle_wide_t imu_w;
		angle_pkg::angle_wide_t full_w;
		tgt_w = angle_pkg::angle_wide_t'(yaw_target);
		imu_w = angle_pkg::angle_wide_t'(imu_yaw);
		full_w = angle_pkg::angle_wide_t'(angle_pkg::ANGLE_360);
		if (throttle_off)
			diff_next = '0;  // nothing to correct on the ground
		else if ((yaw_target > angle_pkg::ANGLE_270) && (imu_yaw < angle_pkg::ANGLE_90))
			diff_next = tgt_w - full_w - imu_w;
		else if ((imu_yaw > angle_pkg::ANGLE_270) && (yaw_target < angle_pkg::ANGLE_90))
			diff_next = full_w - imu_w + tgt_w;
		else
			diff_next = tgt_w - imu_w;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= angle_pkg::YAW_WAIT;
			track <= '0;
			out_of_neutral <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= (state == angle_pkg::YAW_DONE);
			case (state)
				angle_pkg::YAW_WAIT: begin
					if (go)
						state <= angle_pkg::YAW_TRACK;
				end
				angle_pkg::YAW_TRACK: begin
					state <= angle_pkg::YAW_TARGET;
					if (throttle_off) begin
						track <= imu_track;  // follow the craft while disarmed
						out_of_neutral <= 1'b0;
					end else if (stick_neutral) begin
						// resync once after a turn, then hold so the target does not drift
						if (out_of_neutral) begin
							track <= imu_track;
							out_of_neutral <= 1'b0;
						end
					end else begin
						track <= track_step;
						out_of_neutral <= 1'b1;
					end
				end
				angle_pkg::YAW_TARGET: state <= angle_pkg::YAW_ERROR;
				angle_pkg::YAW_ERROR:  state <= angle_pkg::YAW_LIMIT;
				angle_pkg::YAW_LIMIT:  state <= angle_pkg::YAW_DONE;
				angle_pkg::YAW_DONE:   state <= angle_pkg::YAW_WAIT;
				default:               state <= angle_pkg::YAW_WAIT;
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == angle_pkg::YAW_TARGET) begin
			if (throttle_off)
				yaw_target <= imu_yaw;
			else
				yaw_target <= angle_pkg::angle_t'(track >>> 2);  // back to angle scale
		end
		if (state == angle_pkg::YAW_ERROR)
			yaw_diff <= diff_next;
		if (state == angle_pkg::YAW_LIMIT)
			yaw_error <= angle_pkg::clamp_error(yaw_diff);
	end

endmodule

// File: tb/tb_angle_stage.sv
// testbench for angle_stage_top; seed 59, imu yaw kept in 0..360 deg, fixed 7-cycle latency
`timescale 1ns/1ps

module tb_angle_stage;

	logic                     us_clk;
	logic                     resetn;
	logic                     start;
	angle_pkg::rx_sticks_t    sticks;
	angle_pkg::imu_angles_t   imu;
	logic                     busy;
	logic                     done;
	angle_pkg::angle_result_t result;

	int value_errors;
	int protocol_errors;
	int runs;
	bit timed_out;
	int model_track;      // heading at 4x resolution, mirrors the yaw accumulator
	bit model_out_of_neutral;

	angle_stage_top i_dut (
		.us_clk (us_clk),
		.resetn (resetn),
		.start  (start),
		.sticks (sticks),
		.imu    (imu),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		us_clk = 1'b0;
		forever #4 us_clk = ~us_clk;
	end

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED at %0t ns: %s expected %0b got %0b", $time, name, exp, act);
		end
	endtask

	task automatic check_angle(input string name, input angle_pkg::angle_t exp,
		input angle_pkg::angle_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_result(input string name, input angle_pkg::angle_result_t exp,
		input angle_pkg::angle_result_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
			$display("  roll %0d/%0d pitch %0d/%0d yaw_error %0d/%0d yaw_target %0d/%0d",
				exp.roll_error, act.roll_error, exp.pitch_error, act.pitch_error,
				exp.yaw_error, act.yaw_error, exp.yaw_target, act.yaw_target);
		end
	endtask

	task automatic report_protocol_error(input string what);
		protocol_errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	function automatic int clamp_limit(input int e);
		int lim;
		lim = int'(angle_pkg::ERROR_LIMIT);
		if (e > lim)
			return lim;
		if (e < -lim)
			return -lim;
		return e;
	endfunction

	function automatic int tilt_error(input angle_pkg::stick_t thr, input angle_pkg::stick_t stk,
		input angle_pkg::angle_t ang);
		int target;
		if (thr < angle_pkg::THROTTLE_OFF)
			target = 0;
		else
			target = (int'(stk) - int'(angle_pkg::STICK_CENTER)) * (1 << angle_pkg::TILT_SHIFT);
		return clamp_limit(target - int'(ang));
	endfunction

	// reference heading update, once per accepted start
	task automatic yaw_model_step(input angle_pkg::rx_sticks_t s, input angle_pkg::imu_angles_t a,
		output int tgt, output int err);
		int imu_yaw;
		int full;
		int sum;
		bit thr_off;
		imu_yaw = int'(a.yaw);
		full = int'(angle_pkg::ANGLE_360);
		thr_off = s.throttle < angle_pkg::THROTTLE_OFF;
		if (thr_off) begin
			model_track = imu_yaw * 4;
			model_out_of_neutral = 1'b0;
		end else if (s.yaw > angle_pkg::NEUTRAL_LO && s.yaw < angle_pkg::NEUTRAL_HI) begin
			if (model_out_of_neutral) begin
				model_track = imu_yaw * 4;
				model_out_of_neutral = 1'b0;
			end
		end else begin
			sum = model_track + int'(s.yaw) - int'(angle_pkg::STICK_CENTER);
			if (sum > full * 4)
				sum = sum - full * 4;
			else if (sum < 0)
				sum = sum + full * 4;
			model_track = sum;
			model_out_of_neutral = 1'b1;
		end
		tgt = thr_off ? imu_yaw : (model_track >>> 2);
		if (thr_off)
			err = 0;
		else if (tgt > int'(angle_pkg::ANGLE_270) && imu_yaw < int'(angle_pkg::ANGLE_90))
			err = tgt - full - imu_yaw;
		else if (imu_yaw > int'(angle_pkg::ANGLE_270) && tgt < int'(angle_pkg::ANGLE_90))
			err = full - imu_yaw + tgt;
		else
			err = tgt - imu_yaw;
		err = clamp_limit(err);
	endtask

	function automatic angle_pkg::rx_sticks_t random_sticks();
		angle_pkg::rx_sticks_t s;
		s.throttle = angle_pkg::stick_t'($urandom_range(250, 10));
		s.roll = angle_pkg::stick_t'($urandom_range(250, 0));
		s.pitch = angle_pkg::stick_t'($urandom_range(250, 0));
		s.yaw = angle_pkg::stick_t'($urandom_range(250, 0));
		return s;
	endfunction

	// any yaw stick outside the open window 120..130, edges included
	function automatic angle_pkg::stick_t random_active_stick();
		if ($urandom_range(1, 0) == 1)
			return angle_pkg::stick_t'($urandom_range(120, 0));
		return angle_pkg::stick_t'($urandom_range(250, 130));
	endfunction

	function automatic angle_pkg::imu_angles_t random_imu(input bit near_seam);
		angle_pkg::imu_angles_t a;
		int v;
		a.roll = angle_pkg::angle_t'(int'($urandom_range(16000, 0)) - 8000);
		a.pitch = angle_pkg::angle_t'(int'($urandom_range(16000, 0)) - 8000);
		if (near_seam) begin
			v = int'($urandom_range(599, 0));
			a.yaw = angle_pkg::angle_t'((v < 300) ? v : v + 5160);  // 0..299 or 5460..5759
		end else begin
			a.yaw = angle_pkg::angle_t'($urandom_range(5759, 0));
		end
		return a;
	endfunction

	// inputs are don't care while busy
	task automatic scramble_inputs();
		sticks = angle_pkg::rx_sticks_t'($urandom);
		imu = angle_pkg::imu_angles_t'({$urandom, 16'($urandom)});
	endtask

	task automatic run_snapshot(input angle_pkg::rx_sticks_t s, input angle_pkg::imu_angles_t a,
		input bit poke_busy, output angle_pkg::angle_result_t got);
		angle_pkg::angle_result_t exp_res;
		int yaw_tgt;
		int yaw_err;
		int lat;
		got = '0;
		if (timed_out)
			return;
		@(negedge us_clk);
		if (busy)
			report_protocol_error("stage still busy when a new start was due");
		yaw_model_step(s, a, yaw_tgt, yaw_err);
		exp_res.roll_error = angle_pkg::angle_t'(tilt_error(s.throttle, s.roll, a.roll));
		exp_res.pitch_error = angle_pkg::angle_t'(tilt_error(s.throttle, s.pitch, a.pitch));
		exp_res.yaw_error = angle_pkg::angle_t'(yaw_err);
		exp_res.yaw_target = angle_pkg::angle_t'(yaw_tgt);
		start = 1'b1;
		sticks = s;
		imu = a;
		@(negedge us_clk);  // start sampled at edge 0
		start = 1'b0;
		scramble_inputs();
		check_flag("busy", 1'b1, busy);
		lat = 0;
		while (!done && lat < 50) begin
			@(negedge us_clk);
			lat++;
			start = poke_busy && (lat == 2);  // must be dropped by the sequencer
			scramble_inputs();
			if (!done)
				check_flag("busy", 1'b1, busy);
		end
		if (!done) begin
			report_protocol_error("no done within 50 cycles of start");
			timed_out = 1'b1;
			return;
		end
		runs++;
		if (lat != 7)
			report_protocol_error($sformatf("done came %0d cycles after start, not 7", lat));
		check_flag("busy", 1'b0, busy);
		check_result("result", exp_res, result);
		got = result;
		@(negedge us_clk);
		check_flag("done", 1'b0, done);   // strobe lasts one cycle
		check_flag("busy", 1'b0, busy);
	endtask

	task automatic idle_after_reset();
		for (int i = 0; i < 10; i++) begin
			@(negedge us_clk);
			check_flag("busy", 1'b0, busy);
			check_flag("done", 1'b0, done);
		end
		check_result("result", '0, result);
	endtask

	task automatic throttle_off_runs();
		angle_pkg::rx_sticks_t s;
		angle_pkg::imu_angles_t a;
		angle_pkg::angle_result_t got;
		for (int i = 0; i < 8; i++) begin
			s = random_sticks();
			s.throttle = angle_pkg::stick_t'($urandom_range(9, 0));
			a = random_imu(i[0]);
			run_snapshot(s, a, 1'b0, got);
			if (timed_out)
				return;
			check_angle("yaw_target", a.yaw, got.yaw_target);
			check_angle("yaw_error", '0, got.yaw_error);
			check_angle("roll_error", angle_pkg::angle_t'(clamp_limit(-int'(a.roll))),
				got.roll_error);
			check_angle("pitch_error", angle_pkg::angle_t'(clamp_limit(-int'(a.pitch))),
				got.pitch_error);
		end
	endtask

	// park near one side of the seam with the throttle off, then turn across it
	task automatic seam_crossing(input int park_yaw, input int stick_lo, input int stick_hi);
		angle_pkg::rx_sticks_t s;
		angle_pkg::imu_angles_t a;
		angle_pkg::angle_result_t got;
		s = random_sticks();
		s.throttle = 8'd0;
		a = random_imu(1'b0);
		a.yaw = angle_pkg::angle_t'(park_yaw);
		run_snapshot(s, a, 1'b0, got);
		for (int i = 0; i < 12; i++) begin
			s = random_sticks();
			s.yaw = angle_pkg::stick_t'($urandom_range(stick_hi, stick_lo));
			run_snapshot(s, random_imu(1'b1), 1'b0, got);
		end
	endtask

	task automatic neutral_resync_runs();
		angle_pkg::rx_sticks_t s;
		angle_pkg::imu_angles_t a;
		angle_pkg::angle_result_t got;
		angle_pkg::angle_t hold_yaw;
		for (int k = 0; k < 3; k++) begin
			s = random_sticks();
			s.yaw = random_active_stick();
			run_snapshot(s, random_imu(1'b0), 1'b0, got);
			hold_yaw = angle_pkg::angle_t'($urandom_range(5400, 300));
			for (int i = 0; i < 5; i++) begin
				s = random_sticks();
				s.yaw = angle_pkg::stick_t'($urandom_range(129, 121));
				a = random_imu(1'b0);
				// first neutral run resyncs, the rest see a drifting imu
				a.yaw = (i == 0) ? hold_yaw :
					angle_pkg::angle_t'(int'(hold_yaw) + int'($urandom_range(400, 0)) - 200);
				run_snapshot(s, a, 1'b0, got);
				if (timed_out)
					return;
				check_angle("yaw_target", hold_yaw, got.yaw_target);
			end
		end
	endtask

	task automatic mixed_random_runs(input int count, input bit poke_busy);
		angle_pkg::rx_sticks_t s;
		angle_pkg::angle_result_t got;
		for (int i = 0; i < count; i++) begin
			s = random_sticks();
			if ($urandom_range(7, 0) == 0)
				s.throttle = angle_pkg::stick_t'($urandom_range(9, 0));
			else if (i[0])
				s.yaw = random_active_stick();
			run_snapshot(s, random_imu(i[1]), poke_busy, got);
		end
	endtask

	initial begin
		int unsigned seed_ret;
		resetn = 1'b0;
		start = 1'b0;
		sticks = '0;
		imu = '0;
		value_errors = 0;
		protocol_errors = 0;
		runs = 0;
		timed_out = 1'b0;
		model_track = 0;
		model_out_of_neutral = 1'b0;
		seed_ret = $urandom(59);
		repeat (5) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;

		idle_after_reset();
		throttle_off_runs();
		seam_crossing(60, 0, 20);       // left turn through 0 deg
		seam_crossing(5700, 230, 250);  // right turn through 360 deg
		neutral_resync_runs();
		mixed_random_runs(40, 1'b0);
		mixed_random_runs(8, 1'b1);

		$display("errors: value %0d, protocol %0d, after %0d runs",
			value_errors, protocol_errors, runs);
		if (value_errors == 0 && protocol_errors == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
